// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_alu_array
FILELIST := build.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
FAIL_MSG := FAIL: see errors above
SOURCES  := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
design/alu_pkg.sv
design/lane_if.sv
design/op_dispatch.sv
design/alu_lane.sv
design/result_collect.sv
design/alu_array_top.sv
tb/alu_scoreboard.sv
tb/alu_array_chk.sv
tb/tb_alu_array.sv

// ==== design/alu_array_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_array_top (
	input  logic                                     clk,
	input  logic                                     arst_n,
	input  logic                                     in_valid,
	input  alu_pkg::alu_op_e                         op,
	input  logic [alu_pkg::LANES*alu_pkg::WIDTH-1:0] a_bus,
	input  logic [alu_pkg::LANES*alu_pkg::WIDTH-1:0] b_bus,
	output logic                                     out_valid,
	output logic [alu_pkg::LANES*alu_pkg::WIDTH-1:0] result_bus,
	output logic [alu_pkg::LANES-1:0]                carry_bus,
	output logic [alu_pkg::LANES-1:0]                zero_bus
);
	import alu_pkg::*;

	lane_if lane_bus [LANES] (); // one request/result channel per lane

	// ============================================================
	// dispatch, lanes, collect
	// ============================================================

	op_dispatch u_dispatch (
		.clk      (clk),
		.arst_n   (arst_n),
		.in_valid (in_valid),
		.op       (op),
		.a_bus    (a_bus),
		.b_bus    (b_bus),
		.lanes    (lane_bus)
	);

	genvar i;
	generate
		for (i = 0; i < LANES; i++)
		begin : g_lane
			alu_lane u_lane (
				.clk    (clk),
				.arst_n (arst_n),
				.port   (lane_bus[i])
			);
		end
	endgenerate

	result_collect u_collect (
		.clk        (clk),
		.arst_n     (arst_n),
		.lanes      (lane_bus),
		.out_valid  (out_valid),
		.result_bus (result_bus),
		.carry_bus  (carry_bus),
		.zero_bus   (zero_bus)
	);

endmodule

`default_nettype wire

// ==== design/alu_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_lane (
	input  logic clk,
	input  logic arst_n,
	lane_if.lane port
);
	import alu_pkg::*;

	logic [WIDTH-1:0] b_eff;    // b, or ~b when subtracting
	logic [WIDTH-1:0] sum;
	logic [WIDTH:0]   carry;    // carry[0] is the carry in
	logic             sum_zero;
	logic             set_bit;
	logic             use_set;
	logic [WIDTH-1:0] lane_res;

	// ============================================================
	// ripple carry adder / subtractor
	// ============================================================

	assign b_eff    = port.sub ? ~port.b : port.b;
	assign carry[0] = port.sub; // the +1 of two's complement

	genvar i;
	generate
		for (i = 0; i < WIDTH; i++)
		begin : g_bit
			// full adder cell
			assign sum[i]     = port.a[i] ^ b_eff[i] ^ carry[i];
			assign carry[i+1] = (port.a[i] & b_eff[i])
				| (port.a[i] & carry[i])
				| (b_eff[i] & carry[i]);
		end
	endgenerate

	assign sum_zero = (sum == '0);

	// ============================================================
	// set compare
	// ============================================================

	// with sub set, carry out means a >= b unsigned and a zero sum means a == b
	always_comb
	begin
		set_bit = 1'b0;
		use_set = 1'b1;
		case (port.cond)
			COND_EQ: set_bit = sum_zero;
			COND_NE: set_bit = ~sum_zero;
			COND_LT: set_bit = ~carry[WIDTH];
			COND_GT: set_bit = carry[WIDTH] & ~sum_zero;
			COND_LE: set_bit = ~carry[WIDTH] | sum_zero;
			COND_GE: set_bit = carry[WIDTH];
			default: use_set = 1'b0; // COND_NONE
		endcase
		lane_res = use_set ? {{(WIDTH-1){1'b0}}, set_bit} : sum;
	end

	// ============================================================
	// result register
	// ============================================================

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			port.res_valid <= 1'b0;
			port.result    <= '0;
			port.cout      <= 1'b0;
		end
		else
		begin
			port.res_valid <= port.req_valid;
			if (port.req_valid)
			begin
				port.result <= lane_res;
				port.cout   <= carry[WIDTH]; // raw carry, kept for set ops too
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

	// ============================================================
	// sizes
	// ============================================================

	localparam int WIDTH   = 32; // operand width of one lane
	localparam int LANES   = 4;  // lanes sharing one opcode
	localparam int LATENCY = 3;  // in_valid to out_valid, in cycles

	// ============================================================
	// opcodes
	// ============================================================

	typedef enum logic [2:0] {
		ADD = 3'd0, // a + b
		SUB = 3'd1, // a + ~b + 1
		SEQ = 3'd2, // set if a == b
		SNE = 3'd3, // set if a != b
		SLT = 3'd4, // set if a < b, unsigned
		SGT = 3'd5, // set if a > b, unsigned
		SLE = 3'd6, // set if a <= b, unsigned
		SGE = 3'd7  // set if a >= b, unsigned
	} alu_op_e;

	// ============================================================
	// set conditions seen by a lane
	// ============================================================

	// all set conditions come from the subtractor's sum and carry-out
	typedef enum logic [2:0] {
		COND_NONE = 3'd0, // plain sum goes out
		COND_EQ   = 3'd1, // sum is zero
		COND_NE   = 3'd2, // sum is not zero
		COND_LT   = 3'd3, // carry clear
		COND_GT   = 3'd4, // carry set and sum not zero
		COND_LE   = 3'd5, // carry clear or sum zero
		COND_GE   = 3'd6  // carry set
	} cmp_cond_e;

endpackage

`default_nettype wire

// ==== design/lane_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface lane_if;
	import alu_pkg::*;

	// request, from the dispatcher
	logic             req_valid;
	logic             sub;       // invert b and carry in a one
	cmp_cond_e        cond;
	logic [WIDTH-1:0] a;
	logic [WIDTH-1:0] b;

	// result, from the lane
	logic             res_valid; // one cycle after req_valid
	logic [WIDTH-1:0] result;
	logic             cout;

	modport disp (
		output req_valid, sub, cond, a, b
	);

	modport lane (
		input  req_valid, sub, cond, a, b,
		output res_valid, result, cout
	);

	modport coll (
		input res_valid, result, cout
	);

endinterface

`default_nettype wire

// ==== design/op_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module op_dispatch (
	input  logic                                     clk,
	input  logic                                     arst_n,
	input  logic                                     in_valid,
	input  alu_pkg::alu_op_e                         op,
	input  logic [alu_pkg::LANES*alu_pkg::WIDTH-1:0] a_bus,
	input  logic [alu_pkg::LANES*alu_pkg::WIDTH-1:0] b_bus,
	lane_if.disp                                     lanes [alu_pkg::LANES]
);
	import alu_pkg::*;

	logic      sub_d;
	cmp_cond_e cond_d;

	// ============================================================
	// opcode decode, shared by every lane
	// ============================================================

	always_comb
	begin
		sub_d  = 1'b1; // everything but ADD runs the subtractor
		cond_d = COND_NONE;
		case (op)
			ADD:
			begin
				sub_d  = 1'b0;
				cond_d = COND_NONE;
			end
			SUB:     cond_d = COND_NONE;
			SEQ:     cond_d = COND_EQ;
			SNE:     cond_d = COND_NE;
			SLT:     cond_d = COND_LT;
			SGT:     cond_d = COND_GT;
			SLE:     cond_d = COND_LE;
			SGE:     cond_d = COND_GE;
			default: cond_d = COND_NONE;
		endcase
	end

	// ============================================================
	// request registers, one set per lane
	// ============================================================

	genvar i;
	generate
		for (i = 0; i < LANES; i++)
		begin : g_req
			always_ff @(posedge clk or negedge arst_n)
			begin
				if (!arst_n)
				begin
					lanes[i].req_valid <= 1'b0;
					lanes[i].sub       <= 1'b0;
					lanes[i].cond      <= COND_NONE;
					lanes[i].a         <= '0;
					lanes[i].b         <= '0;
				end
				else
				begin
					lanes[i].req_valid <= in_valid;
					if (in_valid)
					begin
						lanes[i].sub  <= sub_d;
						lanes[i].cond <= cond_d;
						lanes[i].a    <= a_bus[i*WIDTH +: WIDTH]; // lane 0 in the low bits
						lanes[i].b    <= b_bus[i*WIDTH +: WIDTH];
					end
				end
			end
		end
	endgenerate

endmodule

`default_nettype wire

// ==== design/result_collect.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_collect (
	input  logic                                     clk,
	input  logic                                     arst_n,
	lane_if.coll                                     lanes [alu_pkg::LANES],
	output logic                                     out_valid,
	output logic [alu_pkg::LANES*alu_pkg::WIDTH-1:0] result_bus,
	output logic [alu_pkg::LANES-1:0]                carry_bus,
	output logic [alu_pkg::LANES-1:0]                zero_bus
);
	import alu_pkg::*;

	logic [WIDTH-1:0] res_w [LANES];
	logic             res_v [LANES];
	logic             cout_w [LANES];

	// flatten the interface array so one process can pack it
	genvar i;
	generate
		for (i = 0; i < LANES; i++)
		begin : g_tap
			assign res_w[i]  = lanes[i].result;
			assign res_v[i]  = lanes[i].res_valid;
			assign cout_w[i] = lanes[i].cout;
		end
	endgenerate

	// ============================================================
	// output registers
	// ============================================================

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			out_valid  <= 1'b0;
			result_bus <= '0;
			carry_bus  <= '0;
			zero_bus   <= '0;
		end
		else
		begin
			out_valid <= res_v[0]; // lanes move in lockstep
			for (int n = 0; n < LANES; n++)
			begin
				if (res_v[n])
				begin
					result_bus[n*WIDTH +: WIDTH] <= res_w[n];
					carry_bus[n]                 <= cout_w[n];
					zero_bus[n]                  <= (res_w[n] == '0);
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb/alu_array_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_array_chk (
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	input logic out_valid
);
	import alu_pkg::*;

	// ============================================================
	// top level timing
	// ============================================================

	a_out_follows_in: assert property (@(posedge clk) disable iff (!arst_n)
		$past(in_valid, LATENCY) |-> out_valid)
		else $error("out_valid missing %0d cycles after in_valid", LATENCY);

	a_no_stray_out: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid |-> $past(in_valid, LATENCY))
		else $error("out_valid without in_valid %0d cycles earlier", LATENCY);

	a_reset_quiet: assert property (@(posedge clk)
		!arst_n |-> !out_valid)
		else $error("out_valid high during reset");

endmodule

`default_nettype wire

// ==== tb/alu_golden.txt ====
// op a0 a1 a2 a3 b0 b1 b2 b3 r0 r1 r2 r3 carry_mask, all hex, lane 0 first
// op: 0 add, 1 sub, 2 seq, 3 sne, 4 slt, 5 sgt, 6 sle, 7 sge
0 00000001 FFFFFFFF 80000000 12345678 00000002 00000001 80000000 11111111 3 0 0 23456789 6
0 0 7FFFFFFF FFFFFFFF DEADBEEF 0 1 FFFFFFFF 21524111 0 80000000 FFFFFFFE 0 C
1 5 0 FFFFFFFF 12345678 3 1 FFFFFFFF 12345679 2 FFFFFFFF 0 FFFFFFFF 5
1 80000000 10 0 A5A5A5A5 1 20 0 5A5A5A5A 7FFFFFFF FFFFFFF0 0 4B4B4B4B D
2 7 0 FFFFFFFF 12345678 7 1 FFFFFFFF 87654321 1 0 1 0 5
3 7 0 FFFFFFFF 87654321 7 1 FFFFFFFE 12345678 0 1 1 1 D
4 1 2 0 FFFFFFFF 2 1 0 0 1 0 0 0 E
4 0 FFFFFFFE 7FFFFFFF 80000000 FFFFFFFF FFFFFFFF 80000000 7FFFFFFF 1 1 1 0 8
5 2 1 5 FFFFFFFF 1 2 5 0 1 0 0 1 D
5 0 80000000 FFFFFFFF 7FFFFFFF FFFFFFFF 7FFFFFFF FFFFFFFE 80000000 0 1 1 0 6
6 1 2 5 0 2 1 5 FFFFFFFF 1 0 1 1 6
6 FFFFFFFF FFFFFFFF 0 80000000 FFFFFFFF 0 0 7FFFFFFF 1 0 1 0 F
7 1 2 5 0 2 1 5 FFFFFFFF 0 1 1 0 6
7 FFFFFFFF 0 80000000 7FFFFFFF 0 0 7FFFFFFF 80000000 1 1 1 0 7
0 10 20 30 40 1 2 3 4 11 22 33 44 0
1 40 30 20 10 40 31 1F 0 0 FFFFFFFF 1 10 D
2 0 0 1 ABCD 0 FFFFFFFF 1 ABCE 1 0 1 0 5
3 0 0 1 ABCD 0 FFFFFFFF 1 ABCE 0 1 0 1 5
0 FFFFFFFF FFFFFFFF 1 0 1 FFFFFFFF FFFFFFFF 0 0 FFFFFFFE 0 0 7
1 0 FFFFFFFF 1 80000000 FFFFFFFF 0 2 80000001 1 FFFFFFFF FFFFFFFF FFFFFFFF 2

// ==== tb/alu_scoreboard.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_scoreboard (
	input  logic                                     clk,
	input  logic                                     arst_n,
	input  logic                                     exp_valid,
	input  logic [alu_pkg::LANES*alu_pkg::WIDTH-1:0] exp_result,
	input  logic [alu_pkg::LANES-1:0]                exp_carry,
	input  logic                                     out_valid,
	input  logic [alu_pkg::LANES*alu_pkg::WIDTH-1:0] result_bus,
	input  logic [alu_pkg::LANES-1:0]                carry_bus,
	input  logic [alu_pkg::LANES-1:0]                zero_bus,
	output int                                       error_count,
	output int                                       checked,
	output int                                       pending
);
	import alu_pkg::*;

	logic [LANES*WIDTH-1:0] res_q [$];   // expected results, arrival order
	logic [LANES-1:0]       carry_q [$];
	int                     cycle_q [$]; // cycle each operation was accepted
	int                     cycle;
	int                     errs;
	int                     done;

	always @(posedge clk)
	begin : compare
		logic [LANES*WIDTH-1:0] exp_r;
		logic [LANES-1:0]       exp_c;
		logic [WIDTH-1:0]       exp_w;
		int                     age;
		if (arst_n)
		begin
			cycle++;
			if (out_valid && res_q.size() == 0)
			begin
				$display("out_valid pulsed at cycle %0d with no operation pending", cycle);
				errs++;
			end
			else if (out_valid)
			begin
				exp_r = res_q.pop_front();
				exp_c = carry_q.pop_front();
				age   = cycle - cycle_q.pop_front();
				if (age != LATENCY)
				begin
					$display("output came %0d cycles after in_valid instead of %0d", age, LATENCY);
					errs++;
				end
				for (int n = 0; n < LANES; n++)
				begin
					exp_w = exp_r[n*WIDTH +: WIDTH];
					if (result_bus[n*WIDTH +: WIDTH] !== exp_w)
					begin
						$display("Error: result_bus lane %0d expected %08h actual %08h",
							n, exp_w, result_bus[n*WIDTH +: WIDTH]);
						errs++;
					end
					if (carry_bus[n] !== exp_c[n])
					begin
						$display("Error: carry_bus lane %0d expected %h actual %h",
							n, exp_c[n], carry_bus[n]);
						errs++;
					end
					if (zero_bus[n] !== (exp_w == '0)) // zero flag follows the result
					begin
						$display("Error: zero_bus lane %0d expected %h actual %h",
							n, (exp_w == '0), zero_bus[n]);
						errs++;
					end
				end
				done++;
			end
			if (exp_valid) // same edge the DUT takes in_valid
			begin
				res_q.push_back(exp_result);
				carry_q.push_back(exp_carry);
				cycle_q.push_back(cycle);
			end
		end
		error_count <= errs;
		checked     <= done;
		pending     <= res_q.size();
	end

endmodule

`default_nettype wire

// ==== tb/tb_alu_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_alu_array;
	import alu_pkg::*;

	localparam int FIELDS      = 2 + 3*LANES; // op, a, b, result, carry mask
	localparam int MAX_OPS     = 64;
	localparam int DRAIN_LIMIT = 50;          // cycles

	logic                   clk;
	logic                   arst_n;
	logic                   in_valid;
	alu_op_e                op;
	logic [LANES*WIDTH-1:0] a_bus;
	logic [LANES*WIDTH-1:0] b_bus;
	logic                   out_valid;
	logic [LANES*WIDTH-1:0] result_bus;
	logic [LANES-1:0]       carry_bus;
	logic [LANES-1:0]       zero_bus;
	logic                   exp_valid;
	logic [LANES*WIDTH-1:0] exp_result;
	logic [LANES-1:0]       exp_carry;
	int                     sb_errors;
	int                     sb_checked;
	int                     sb_pending;
	logic [31:0]            golden [0:MAX_OPS*FIELDS-1];
	int                     num_ops;
	int                     tb_errors;
	int                     seed;
	int                     gap;
	int                     base;
	int                     waited;

	initial clk = 1'b0;
	always #20 clk = ~clk;

	alu_array_top u_alu_array_top (.*);

	alu_scoreboard u_scoreboard (.*, .error_count(sb_errors), .checked(sb_checked),
		.pending(sb_pending));

	bind alu_array_top alu_array_chk u_chk (.clk(clk), .arst_n(arst_n),
		.in_valid(in_valid), .out_valid(out_valid));

	// packs LANES consecutive file words, lane 0 in the low bits
	function automatic logic [LANES*WIDTH-1:0] gather(input int first);
		logic [LANES*WIDTH-1:0] v;
		for (int n = 0; n < LANES; n++)
			v[n*WIDTH +: WIDTH] = golden[first + n];
		return v;
	endfunction

	task automatic load_golden();
		for (int i = 0; i < MAX_OPS*FIELDS; i++)
			golden[i] = 32'hEE00_0000 | i; // no valid opcode, marks the end
		$readmemh("tb/alu_golden.txt", golden);
		num_ops = 0;
		while (num_ops < MAX_OPS && golden[num_ops*FIELDS] < 8)
			num_ops++;
	endtask

	initial
	begin
		seed       = 66448;
		tb_errors  = 0;
		in_valid   <= 1'b0;
		op         <= ADD;
		a_bus      <= '0;
		b_bus      <= '0;
		exp_valid  <= 1'b0;
		exp_result <= '0;
		exp_carry  <= '0;
		arst_n     <= 1'b1;
		load_golden();
		if (num_ops == 0)
		begin
			$display("golden file missing or holds no operations");
			tb_errors++;
		end
		#1 arst_n <= 1'b0;
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);
		for (int k = 0; k < num_ops; k++)
		begin
			gap = {$random(seed)} % 3;
			if (k >= 6 && k < 12)
				gap = 0; // a burst of back to back operations
			repeat (gap)
			begin
				in_valid  <= 1'b0;
				exp_valid <= 1'b0;
				@(posedge clk);
			end
			base       = k * FIELDS;
			in_valid   <= 1'b1;
			op         <= alu_op_e'(golden[base][2:0]);
			a_bus      <= gather(base + 1);
			b_bus      <= gather(base + 1 + LANES);
			exp_valid  <= 1'b1;
			exp_result <= gather(base + 1 + 2*LANES);
			exp_carry  <= golden[base + 1 + 3*LANES][LANES-1:0];
			@(posedge clk);
		end
		in_valid  <= 1'b0;
		exp_valid <= 1'b0;
		repeat (2) @(posedge clk);
		waited = 0;
		while (sb_pending != 0 && waited < DRAIN_LIMIT)
		begin
			@(posedge clk);
			waited++;
		end
		if (sb_pending != 0)
		begin
			$display("outputs stopped arriving, %0d operations never came out", sb_pending);
			tb_errors++;
		end
		repeat (4) @(posedge clk); // room for a stray out_valid
		if (sb_checked != num_ops)
		begin
			$display("sent %0d operations but %0d were checked", num_ops, sb_checked);
			tb_errors++;
		end
		$display("errors: %0d from scoreboard, %0d from testbench", sb_errors, tb_errors);
		if (sb_errors + tb_errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire
